//--- verilog.f
+incdir+dv
common/game_types_pkg.sv
common/game_cfg_pkg.sv
common/stage_ctrl_if.sv
rtl/switch_sync.sv
game_ctrl/game_fsm.sv
game_ctrl/stage_sequencer.sv
rtl/unit_outputs.sv
rtl/game_top.sv
dv/tb_game_top.sv

//--- Makefile
# Verilator build and run of the game controller testbench

VERILATOR ?= verilator
SIM_TOP   ?= tb_game_top
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FLIST)) dv/game_scenarios.svh
BIN  := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/game_scenarios.svh
/*
 * Game scenarios
 * Step table for the game controller testbench, one row per step.
 */

`ifndef GAME_SCENARIOS_SVH
`define GAME_SCENARIOS_SVH

typedef struct packed {
    logic [3:0] lvl;      // start, pause, skip, win levels
    logic [2:0] tap;      // one-cycle skip, win, dead
    logic [7:0] settle;   // cycles before matching starts
    game_stage  stage;
    logic       over;
    logic       won;
    logic [3:0] en;       // player, monst, astero, boss
    logic [3:0] rst;      // active low in the same order
} step_t;

localparam int NUM_STEPS = 20;

// column order is levels, taps, settle, stage_num, game_over, game_won, enables, unit resets
localparam step_t STEPS [NUM_STEPS] = '{
    '{4'b0000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b0000, 4'b0000},   // idle after reset
    '{4'b1000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b1100, 4'b1100},   // start
    '{4'b1100, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b0000, 4'b1100},   // pause
    '{4'b1000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b1100, 4'b1100},   // resume
    '{4'b1000, 3'b100, 8'd0,  STAGE_ASTERO, 1'b0, 1'b0, 4'b1010, 4'b1010},   // skip press
    '{4'b1000, 3'b100, 8'd0,  LAST_STAGE,   1'b0, 1'b0, 4'b1001, 4'b1001},   // skip press
    '{4'b1000, 3'b010, 8'd0,  LAST_STAGE,   1'b1, 1'b1, 4'b0000, 4'b0000},   // boss beaten
    '{4'b0000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b0000, 4'b0000},   // start low
    '{4'b1000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b1100, 4'b1100},   // new game
    '{4'b1000, 3'b100, 8'd0,  STAGE_ASTERO, 1'b0, 1'b0, 4'b1010, 4'b1010},   // skip press
    '{4'b1000, 3'b001, 8'd0,  STAGE_ASTERO, 1'b1, 1'b0, 4'b0000, 4'b0000},   // player dies
    '{4'b0000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b0000, 4'b0000},   // start low
    '{4'b1000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b1100, 4'b1100},   // new game
    '{4'b1010, 3'b000, 8'd24, STAGE_ASTERO, 1'b0, 1'b0, 4'b1010, 4'b1010},   // skip held
    '{4'b1000, 3'b000, 8'd8,  STAGE_ASTERO, 1'b0, 1'b0, 4'b1010, 4'b1010},   // skip released
    '{4'b1001, 3'b000, 8'd24, LAST_STAGE,   1'b0, 1'b0, 4'b1001, 4'b1001},   // win held
    '{4'b1000, 3'b000, 8'd8,  LAST_STAGE,   1'b0, 1'b0, 4'b1001, 4'b1001},   // win released
    '{4'b1100, 3'b000, 8'd0,  LAST_STAGE,   1'b0, 1'b0, 4'b0000, 4'b1001},   // pause in boss stage
    '{4'b1000, 3'b000, 8'd0,  LAST_STAGE,   1'b0, 1'b0, 4'b1001, 4'b1001},   // resume
    '{4'b0000, 3'b000, 8'd0,  FIRST_STAGE,  1'b0, 1'b0, 4'b0000, 4'b0000}    // start low
};

`endif

//--- dv/tb_game_top.sv
/*
 * Game controller testbench
 * Walks the scenario table through the DUT and compares every
 * output with the expected values of each step.
 */

`timescale 1ns/1ps

module tb_game_top
    import game_types_pkg::*;
    import game_cfg_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 50;   // per step, after settle
    localparam logic [31:0] SEED           = 32'h082386e9;

    `include "game_scenarios.svh"

    logic      clk;
    logic      resetN;
    logic      start_game;
    logic      pause;
    logic      skip_stage;
    logic      win_stage;
    logic      player_dead;
    logic      game_won;
    logic      game_over;
    game_stage stage_num;
    logic      enable_player;
    logic      enable_monst;
    logic      enable_astero;
    logic      enable_boss;
    logic      resetN_player;
    logic      resetN_monst;
    logic      resetN_astero;
    logic      resetN_boss;

    int value_errors;
    int timeouts;
    int step_idx;

    game_top #(.SYNC_DEPTH(SYNC_DEPTH)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic check_stage(input string name, input game_stage got, input game_stage exp);
        if (got !== exp) begin
            $display("[ERROR] step %0d %s: got 0x%0h expected 0x%0h",
                     step_idx, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] step %0d %s: got 0x%0h expected 0x%0h",
                     step_idx, name, got, exp);
            value_errors++;
        end
    endtask

    function automatic logic outputs_match(input step_t s);
        return (stage_num === s.stage) && (game_over === s.over) && (game_won === s.won) &&
               ({enable_player, enable_monst, enable_astero, enable_boss} === s.en) &&
               ({resetN_player, resetN_monst, resetN_astero, resetN_boss} === s.rst);
    endfunction

    task automatic check_outputs(input step_t s);
        check_stage("stage_num", stage_num, s.stage);
        check_bit("game_over", game_over, s.over);
        check_bit("game_won", game_won, s.won);
        check_bit("enable_player", enable_player, s.en[3]);
        check_bit("enable_monst", enable_monst, s.en[2]);
        check_bit("enable_astero", enable_astero, s.en[1]);
        check_bit("enable_boss", enable_boss, s.en[0]);
        check_bit("resetN_player", resetN_player, s.rst[3]);
        check_bit("resetN_monst", resetN_monst, s.rst[2]);
        check_bit("resetN_astero", resetN_astero, s.rst[1]);
        check_bit("resetN_boss", resetN_boss, s.rst[0]);
    endtask

    task automatic apply_step(input step_t s);
        @(negedge clk);
        start_game  = s.lvl[3];
        pause       = s.lvl[2];
        skip_stage  = s.lvl[1] | s.tap[2];
        win_stage   = s.lvl[0] | s.tap[1];
        player_dead = s.tap[0];
        if (s.tap != 3'b000) begin
            @(negedge clk);   // taps last one cycle
            skip_stage  = s.lvl[1];
            win_stage   = s.lvl[0];
            player_dead = 1'b0;
        end
        repeat (s.settle) @(negedge clk);
    endtask

    task automatic wait_for_outputs(input step_t s);
        int cycles;
        cycles = 0;
        while (!outputs_match(s) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!outputs_match(s)) begin
            $display("step %0d: outputs did not reach the expected values within %0d cycles",
                     step_idx, TIMEOUT_CYCLES);
            timeouts++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        value_errors = 0;
        timeouts     = 0;
        step_idx     = 0;
        resetN       = 1'b0;
        start_game   = 1'b0;
        pause        = 1'b0;
        skip_stage   = 1'b0;
        win_stage    = 1'b0;
        player_dead  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetN = 1'b1;

        for (int i = 0; i < NUM_STEPS; i++) begin
            step_idx = i;
            apply_step(STEPS[i]);
            wait_for_outputs(STEPS[i]);
            check_outputs(STEPS[i]);
            repeat ($urandom_range(4, 1)) @(negedge clk);   // idle gap, outputs must hold
            check_outputs(STEPS[i]);
        end

        $display("summary: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- rtl/game_top.sv
/*
 * Game controller top
 * Input synchronizer, game FSM, stage sequencer and unit output
 * registers of the three-stage arcade game.
 */

`timescale 1ns/1ps

module game_top
    import game_types_pkg::*;
#(
    parameter int SYNC_DEPTH = game_cfg_pkg::SYNC_DEPTH
) (
    input  logic      clk,
    input  logic      resetN,
    input  logic      start_game,
    input  logic      pause,
    input  logic      skip_stage,
    input  logic      win_stage,
    input  logic      player_dead,
    output logic      game_won,
    output logic      game_over,
    output game_stage stage_num,
    output logic      enable_player,
    output logic      enable_monst,
    output logic      enable_astero,
    output logic      enable_boss,
    output logic      resetN_player,
    output logic      resetN_monst,
    output logic      resetN_astero,
    output logic      resetN_boss
);

    logic      start_sync;
    logic      pause_sync;
    logic      skip_pulse;
    logic      win_pulse;
    game_state fsm_state;

    stage_ctrl_if ctrl_if ();

    switch_sync #(.SYNC_DEPTH(SYNC_DEPTH)) sync_i (
        .clk, .resetN, .start_game, .pause, .skip_stage, .win_stage,
        .start_sync, .pause_sync, .skip_pulse, .win_pulse
    );

    game_fsm fsm_i (
        .clk, .resetN, .start_sync, .pause_sync, .skip_pulse, .win_pulse,
        .player_dead,                                  // already synchronous
        .ctrl(ctrl_if.fsm), .state(fsm_state), .game_over
    );

    stage_sequencer seq_i (.clk, .resetN, .ctrl(ctrl_if.seq), .game_won);

    unit_outputs out_i (
        .clk, .resetN, .state(fsm_state), .units(ctrl_if.units),
        .enable_player, .enable_monst, .enable_astero, .enable_boss,
        .resetN_player, .resetN_monst, .resetN_astero, .resetN_boss
    );

    assign stage_num = ctrl_if.stage_num;

endmodule

//--- rtl/unit_outputs.sv
/*
 * Unit outputs
 * Merges the game state and the stage selection into registered
 * enable and reset lines for the player and the enemy units.
 */

`timescale 1ns/1ps

module unit_outputs
    import game_types_pkg::*;
(
    input  logic      clk,
    input  logic      resetN,
    input  game_state state,
    input  unit_sel   units,
    output logic      enable_player,
    output logic      enable_monst,
    output logic      enable_astero,
    output logic      enable_boss,
    output logic      resetN_player,
    output logic      resetN_monst,
    output logic      resetN_astero,
    output logic      resetN_boss
);

    logic    playing;   // units may move
    logic    alive;     // units keep their state
    unit_sel en_sel;
    unit_sel rst_sel;

    assign playing = (state == ST_RUN) || (state == ST_STAGE_WON);
    assign alive   = (state != ST_RESET) && (state != ST_GAME_OVER);

    // an unselected unit is held in reset, which covers the stage
    // just won during ST_STAGE_WON
    assign en_sel  = units & {3{playing}};
    assign rst_sel = units & {3{alive}};

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            {enable_player, enable_monst, enable_astero, enable_boss} <= '0;
            {resetN_player, resetN_monst, resetN_astero, resetN_boss} <= '0;
        end else begin
            enable_player <= playing;
            resetN_player <= alive;
            {enable_monst, enable_astero, enable_boss} <= en_sel;
            {resetN_monst, resetN_astero, resetN_boss} <= rst_sel;
        end
    end

    a_enable_out_of_reset: assert property (@(posedge clk) disable iff (!resetN)
        (!enable_player || resetN_player) && (!enable_monst || resetN_monst) &&
        (!enable_astero || resetN_astero) && (!enable_boss || resetN_boss))
        else $error("unit enabled while held in reset");

endmodule

//--- game_ctrl/stage_sequencer.sv
/*
 * Stage sequencer
 * Steps through the stages on advance strobes, selects the enemy
 * units of each stage and flags the win after the last one.
 */

`timescale 1ns/1ps

module stage_sequencer
    import game_types_pkg::*;
    import game_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       resetN,
    stage_ctrl_if.seq  ctrl,
    output logic       game_won
);

    game_stage stage_q;
    logic      won_q;
    unit_sel   sel;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_q <= FIRST_STAGE;
            won_q   <= 1'b0;
        end else if (!ctrl.game_active) begin
            stage_q <= FIRST_STAGE;                        // new game starts over
            won_q   <= 1'b0;
        end else if (ctrl.advance) begin
            if (stage_q == LAST_STAGE) begin
                won_q <= 1'b1;                             // stage stays at the last one
            end else begin
                stage_q <= game_stage'(stage_q + 2'd1);
            end
        end
    end

    // one enemy type per stage
    always_comb begin
        sel = '0;
        case (stage_q)
            STAGE_MONST:  sel.monst  = 1'b1;
            STAGE_ASTERO: sel.astero = 1'b1;
            STAGE_BOSS:   sel.boss   = 1'b1;
            default:      sel        = '0;
        endcase
    end

    // once the boss falls no enemy is left selected
    assign ctrl.units     = won_q ? unit_sel'('0) : sel;
    assign ctrl.stage_num = stage_q;
    assign ctrl.game_won  = won_q;
    assign game_won       = won_q;

    a_stage_range: assert property (@(posedge clk) disable iff (!resetN)
        ctrl.stage_num <= LAST_STAGE)
        else $error("stage_num %0h beyond last stage", ctrl.stage_num);

endmodule

//--- game_ctrl/game_fsm.sv
/*
 * Game state machine
 * Runs the game through reset, run, pause, stage won and game over,
 * and asks the stage sequencer to advance when a stage is cleared.
 */

`timescale 1ns/1ps

module game_fsm
    import game_types_pkg::*;
(
    input  logic             clk,
    input  logic             resetN,
    input  logic             start_sync,
    input  logic             pause_sync,
    input  logic             skip_pulse,
    input  logic             win_pulse,
    input  logic             player_dead,   // synchronous pulse from player unit
    stage_ctrl_if.fsm        ctrl,
    output game_state        state,
    output logic             game_over
);

    game_state state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_RESET: begin
                if (start_sync) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                if (pause_sync) begin                          // pause wins
                    state_next = ST_PAUSE;
                end else if (player_dead) begin
                    state_next = ST_GAME_OVER;
                end else if (win_pulse || skip_pulse) begin
                    state_next = ST_STAGE_WON;
                end
            end
            ST_PAUSE: begin
                if (!pause_sync) begin
                    state_next = ST_RUN;
                end
            end
            ST_STAGE_WON: begin
                // sequencer has already taken the advance at this point
                if (ctrl.game_won) begin
                    state_next = ST_GAME_OVER;
                end else begin
                    state_next = ST_RUN;
                end
            end
            ST_GAME_OVER: begin
                state_next = ST_GAME_OVER;                     // wait for start low
            end
            default: begin
                state_next = ST_RESET;
            end
        endcase

        // dropping the start switch ends the game from anywhere
        if (state != ST_RESET && !start_sync) begin
            state_next = ST_RESET;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state     <= ST_RESET;
            game_over <= 1'b0;
        end else begin
            state     <= state_next;
            game_over <= (state_next == ST_GAME_OVER);   // aligned with state
        end
    end

    assign ctrl.game_active = (state != ST_RESET);

    // high on the edge that enters ST_STAGE_WON, so stage_num and
    // game_won are already updated while in ST_STAGE_WON
    assign ctrl.advance = (state == ST_RUN) && (state_next == ST_STAGE_WON);

    a_state_legal: assert property (@(posedge clk) disable iff (!resetN)
        state inside {ST_RESET, ST_RUN, ST_PAUSE, ST_STAGE_WON, ST_GAME_OVER})
        else $error("illegal game state %0h", state);

    a_won_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
        state == ST_STAGE_WON |=> state != ST_STAGE_WON)
        else $error("ST_STAGE_WON held for two cycles");

endmodule

//--- rtl/switch_sync.sv
/*
 * Switch synchronizer
 * Brings the board switches into the clock domain and turns the skip
 * button and the stage-won level into single-cycle pulses.
 */

`timescale 1ns/1ps

module switch_sync #(
    parameter int SYNC_DEPTH = game_cfg_pkg::SYNC_DEPTH
) (
    input  logic clk,
    input  logic resetN,
    input  logic start_game,   // board switch
    input  logic pause,        // board switch
    input  logic skip_stage,   // board button
    input  logic win_stage,    // from enemy units, already synchronous
    output logic start_sync,
    output logic pause_sync,
    output logic skip_pulse,
    output logic win_pulse
);

    logic [2:0] sync_ff [SYNC_DEPTH];   // {start, pause, skip} per stage
    logic [2:0] sync_out;
    logic       skip_d;                 // previous synchronized skip
    logic       win_d;                  // previous win level

    assign sync_out   = sync_ff[SYNC_DEPTH-1];
    assign start_sync = sync_out[2];
    assign pause_sync = sync_out[1];

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            for (int i = 0; i < SYNC_DEPTH; i++) begin
                sync_ff[i] <= '0;
            end
            skip_d     <= 1'b0;
            skip_pulse <= 1'b0;
            win_d      <= 1'b0;
            win_pulse  <= 1'b0;
        end else begin
            sync_ff[0] <= {start_game, pause, skip_stage};
            for (int i = 1; i < SYNC_DEPTH; i++) begin
                sync_ff[i] <= sync_ff[i-1];
            end
            skip_d     <= sync_out[0];
            skip_pulse <= sync_out[0] & ~skip_d;   // held button gives one pulse
            win_d      <= win_stage;
            win_pulse  <= win_stage & ~win_d;       // long win level gives one pulse
        end
    end

    a_skip_single: assert property (@(posedge clk) disable iff (!resetN)
        skip_pulse |=> !skip_pulse)
        else $error("skip_pulse high for two cycles");

endmodule

//--- common/stage_ctrl_if.sv
/*
 * Stage control link
 * Carries the advance request from the game FSM to the stage
 * sequencer and the stage results back.
 */

`timescale 1ns/1ps

interface stage_ctrl_if
    import game_types_pkg::*;
();

    logic      game_active;   // FSM is outside ST_RESET
    logic      advance;       // strobe on entry to ST_STAGE_WON
    game_stage stage_num;     // current stage
    unit_sel   units;         // enemy units of the current stage
    logic      game_won;      // last stage cleared

    modport fsm (
        output game_active,
        output advance,
        input  game_won
    );

    modport seq (
        input  game_active,
        input  advance,
        output stage_num,
        output units,
        output game_won
    );

endinterface

//--- common/game_cfg_pkg.sv
/*
 * Game configuration
 * Default synchronizer depth and the stage order of one game.
 */

package game_cfg_pkg;

    import game_types_pkg::*;

    localparam int SYNC_DEPTH = 2;   // flops per board input

    // a game runs from FIRST_STAGE up to LAST_STAGE
    localparam game_stage FIRST_STAGE = STAGE_MONST;
    localparam game_stage LAST_STAGE  = STAGE_BOSS;

endpackage

//--- common/game_types_pkg.sv
/*
 * Game types
 * Stage and state encodings shared by the game controller,
 * plus the per-stage enemy unit selection.
 */

package game_types_pkg;

    // play order matters, the sequencer counts upward through it
    typedef enum logic [1:0] {
        STAGE_MONST  = 2'd0,   // monsters
        STAGE_ASTERO = 2'd1,   // asteroid field
        STAGE_BOSS   = 2'd2    // boss fight
    } game_stage;

    // top-level game machine
    typedef enum logic [2:0] {
        ST_RESET     = 3'd0,   // waiting for start
        ST_RUN       = 3'd1,   // playing
        ST_PAUSE     = 3'd2,   // frozen by pause switch
        ST_STAGE_WON = 3'd3,   // one cycle between stages
        ST_GAME_OVER = 3'd4    // lost, or all stages cleared
    } game_state;

    // which enemy units take part in the current stage
    typedef struct packed {
        logic monst;
        logic astero;
        logic boss;
    } unit_sel;

endpackage
